// File: marble_ctl_pkg.sv
// ==========================================================================
// Local-bus widths, register map and constants for the board-control core
// Addresses are word addresses; only the low 7 bits are reachable over SPI
// ==========================================================================
package marble_ctl_pkg;

	// Local-bus geometry
	localparam int lb_aw = 8;
	localparam int lb_dw = 32;

	// White Rabbit DAC serial word
	localparam int dac_w = 24;

	// ASCII "MRBL"
	localparam logic [lb_dw-1:0] ctl_id = 32'h4d52424c;

	// Register map
	localparam logic [lb_aw-1:0] reg_id      = 8'd0;
	localparam logic [lb_aw-1:0] reg_led     = 8'd1;
	localparam logic [lb_aw-1:0] reg_dac1    = 8'd2;
	localparam logic [lb_aw-1:0] reg_dac2    = 8'd3;
	localparam logic [lb_aw-1:0] reg_dac_cmd = 8'd4;
	localparam logic [lb_aw-1:0] reg_status  = 8'd5;

	// Read data for holes in the map
	localparam logic [lb_dw-1:0] lb_fill = 32'hfaceface;

endpackage

// File: lb_if.sv
// ==========================================================================
// Single-master local bus; strobe lasts one cycle, read data one cycle later
// ==========================================================================
`timescale 1ns/1ns

interface lb_if;
	import marble_ctl_pkg::*;

	// Request side
	logic             strobe;
	logic             rd;
	logic             write;
	logic [lb_aw-1:0] addr;
	logic [lb_dw-1:0] wdata;

	// Read return
	logic [lb_dw-1:0] rdata;
	logic             rd_valid;

	modport master (
		output strobe, rd, write, addr, wdata,
		input  rdata, rd_valid
	);

	modport slave (
		input  strobe, rd, write, addr, wdata,
		output rdata, rd_valid
	);

endinterface

// File: dac_if.sv
// ==========================================================================
// Four-phase DAC request; data and channel change only with req and ack low
// ==========================================================================
`timescale 1ns/1ns

interface dac_if;
	import marble_ctl_pkg::*;

	logic             req;
	logic             ack;
	logic [dac_w-1:0] data;
	// 0 picks DAC1, 1 picks DAC2
	logic             channel;

	modport host (
		output req, data, channel,
		input  ack
	);

	modport engine (
		input  req, data, channel,
		output ack
	);

endinterface

// File: spi_lb_bridge.sv
// ==========================================================================
// SPI slave oversampled on lb_clk; SCLK half period must be >= 8 lb_clk
// 40-bit frames only, short frames are dropped, MISO idles low
// ==========================================================================
`timescale 1ns/1ns

module spi_lb_bridge (
	input  logic lb_clk,
	input  logic reset,
	input  logic sclk,
	input  logic csb,
	input  logic mosi,
	output logic miso,
	lb_if.master lb
);
	import marble_ctl_pkg::*;

	// Command byte plus data word
	localparam int frame_bits = lb_dw + 8;

	// Two sync stages, third stage for edge detect
	logic [2:0] sclk_s;
	logic [2:0] csb_s;
	logic [1:0] mosi_s;

	logic       sclk_rise;
	logic       sclk_fall;
	logic       csb_fall;
	logic       csb_rise;
	logic       csb_act;

	logic [5:0]       bit_cnt;
	logic [lb_dw-1:0] shift_in;
	// Bit 7 read flag, bits 6..0 address
	logic [7:0]       cmd;

	// Read return path
	logic             tx_act;
	logic             miso_q;
	logic [lb_dw-1:0] miso_sr;

	always_ff @(posedge lb_clk) begin
		if (reset) begin
			sclk_s <= 3'b000;
			// Idle deselected so no false frame start
			csb_s  <= 3'b111;
			mosi_s <= 2'b00;
		end else begin
			sclk_s <= {sclk_s[1:0], sclk};
			csb_s  <= {csb_s[1:0], csb};
			mosi_s <= {mosi_s[0], mosi};
		end
	end

	assign sclk_rise = sclk_s[1] & ~sclk_s[2];
	assign sclk_fall = ~sclk_s[1] & sclk_s[2];
	assign csb_fall  = ~csb_s[1] & csb_s[2];
	assign csb_rise  = csb_s[1] & ~csb_s[2];
	assign csb_act   = ~csb_s[1];

	// Bit counter and strobe generation
	always_ff @(posedge lb_clk) begin
		lb.strobe <= 1'b0;
		lb.rd     <= 1'b0;
		lb.write  <= 1'b0;
		if (reset) begin
			bit_cnt <= '0;
		end else begin
			if (csb_fall) begin
				bit_cnt <= '0;
			end else if (sclk_rise && csb_act && bit_cnt != 6'(frame_bits)) begin
				bit_cnt <= bit_cnt + 6'd1;
				// 8th bit completes the command; reads go out right away
				if (bit_cnt == 6'd7 && shift_in[6]) begin
					lb.strobe <= 1'b1;
					lb.rd     <= 1'b1;
				end
			end
			// Writes only for full frames
			if (csb_rise && bit_cnt == 6'(frame_bits) && !cmd[7]) begin
				lb.strobe <= 1'b1;
				lb.write  <= 1'b1;
			end
		end
	end

	// Shift register and command capture
	always_ff @(posedge lb_clk) begin
		if (sclk_rise && csb_act && bit_cnt != 6'(frame_bits)) begin
			shift_in <= {shift_in[lb_dw-2:0], mosi_s[1]};
			if (bit_cnt == 6'd7)
				cmd <= {shift_in[6:0], mosi_s[1]};
		end
	end

	// Data word stays put once the 40th bit is in
	assign lb.addr  = {{(lb_aw-7){1'b0}}, cmd[6:0]};
	assign lb.wdata = shift_in;

	// MISO control
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			tx_act <= 1'b0;
			miso_q <= 1'b0;
		end else if (!csb_act) begin
			tx_act <= 1'b0;
			miso_q <= 1'b0;
		end else begin
			if (lb.rd_valid)
				tx_act <= 1'b1;
			// Next bit presented on each falling edge
			if (sclk_fall && tx_act)
				miso_q <= miso_sr[lb_dw-1];
		end
	end

	// Zeros shift in, so MISO returns low after bit 0
	always_ff @(posedge lb_clk) begin
		if (lb.rd_valid)
			miso_sr <= lb.rdata;
		else if (sclk_fall && tx_act)
			miso_sr <= {miso_sr[lb_dw-2:0], 1'b0};
	end

	assign miso = miso_q;

endmodule

// File: ctl_reg_bank.sv
// ==========================================================================
// Register bank; a DAC command while busy is dropped without any trace
// ==========================================================================
`timescale 1ns/1ns

module ctl_reg_bank (
	input  logic       lb_clk,
	input  logic       reset,
	input  logic [7:0] pmod_in,
	output logic [9:0] led_out,
	lb_if.slave        lb,
	dac_if.host        dac
);
	import marble_ctl_pkg::*;

	logic [9:0]       led_r;
	logic [dac_w-1:0] dac1_r;
	logic [dac_w-1:0] dac2_r;
	logic             busy;
	logic [7:0]       done_cnt;
	logic             ack_d;
	logic [7:0]       pmod_s1;
	logic [7:0]       pmod_s2;
	logic [lb_dw-1:0] rd_word;

	// Pmod2 pins are asynchronous
	always_ff @(posedge lb_clk) begin
		pmod_s1 <= pmod_in;
		pmod_s2 <= pmod_s1;
	end

	// Writes and DAC handshake
	always_ff @(posedge lb_clk) begin
		if (reset) begin
			led_r    <= '0;
			dac1_r   <= '0;
			dac2_r   <= '0;
			busy     <= 1'b0;
			done_cnt <= '0;
			dac.req  <= 1'b0;
			ack_d    <= 1'b0;
		end else begin
			ack_d <= dac.ack;
			if (lb.strobe && lb.write) begin
				case (lb.addr)
					reg_led:  led_r  <= lb.wdata[9:0];
					reg_dac1: dac1_r <= lb.wdata[dac_w-1:0];
					reg_dac2: dac2_r <= lb.wdata[dac_w-1:0];
					reg_dac_cmd: begin
						if (!busy) begin
							busy    <= 1'b1;
							dac.req <= 1'b1;
						end
					end
					default: ;
				endcase
			end
			// Phase 3 of the handshake
			if (dac.ack)
				dac.req <= 1'b0;
			// Transfer closed once ack falls
			if (ack_d && !dac.ack) begin
				busy     <= 1'b0;
				done_cnt <= done_cnt + 8'd1;
			end
		end
	end

	// Word and channel only move while idle
	always_ff @(posedge lb_clk) begin
		if (lb.strobe && lb.write && lb.addr == reg_dac_cmd && !busy) begin
			dac.channel <= lb.wdata[0];
			dac.data    <= lb.wdata[0] ? dac2_r : dac1_r;
		end
	end

	// Read decode
	always_comb begin
		case (lb.addr)
			reg_id:     rd_word = ctl_id;
			reg_led:    rd_word = {{(lb_dw-10){1'b0}}, led_r};
			reg_dac1:   rd_word = {{(lb_dw-dac_w){1'b0}}, dac1_r};
			reg_dac2:   rd_word = {{(lb_dw-dac_w){1'b0}}, dac2_r};
			reg_status: rd_word = {8'h00, pmod_s2, done_cnt, 7'h00, busy};
			default:    rd_word = lb_fill;
		endcase
	end

	// Read data one cycle after the strobe
	always_ff @(posedge lb_clk) begin
		if (reset)
			lb.rd_valid <= 1'b0;
		else
			lb.rd_valid <= lb.strobe & lb.rd;
	end

	always_ff @(posedge lb_clk) begin
		if (lb.strobe && lb.rd)
			lb.rdata <= rd_word;
	end

	assign led_out = led_r;

endmodule

// File: dac_seq_fsm.sv
// ==========================================================================
// One DAC transfer per request; ack rises one cycle after sync goes high
// ==========================================================================
`timescale 1ns/1ns

module dac_seq_fsm (
	input  logic lb_clk,
	input  logic reset,
	input  logic half_tick,
	input  logic last_bit,
	output logic timer_run,
	output logic shift_load,
	output logic sync_en,
	dac_if.engine dac
);

	typedef enum logic [2:0] {
		idle,
		load,
		shift,
		sync_hold,
		ack_wait
	} state_t;

	state_t state;
	logic   ack_q;

	always_ff @(posedge lb_clk) begin
		if (reset) begin
			state <= idle;
			ack_q <= 1'b0;
		end else begin
			// Held until the host drops req
			ack_q <= (state == ack_wait) && dac.req;
			case (state)
				idle:      if (dac.req && !ack_q) state <= load;
				load:      state <= shift;
				// 48th half period done
				shift:     if (half_tick && last_bit) state <= sync_hold;
				// One more half period with sync low
				sync_hold: if (half_tick) state <= ack_wait;
				ack_wait:  if (!dac.req) state <= idle;
				default:   state <= idle;
			endcase
		end
	end

	// Moore outputs to timer and shifter
	assign shift_load = (state == load);
	assign timer_run  = (state == shift) || (state == sync_hold);
	assign sync_en    = (state == load) || timer_run;
	assign dac.ack    = ack_q;

endmodule

// File: dac_bit_timer.sv
// ==========================================================================
// Half-period ticks every clk_div cycles (clk_div >= 2), 48 SCLK toggles max
// ==========================================================================
`timescale 1ns/1ns

module dac_bit_timer #(
	parameter int clk_div = 4
) (
	input  logic lb_clk,
	input  logic reset,
	input  logic run,
	output logic half_tick,
	output logic sclk,
	output logic last_bit
);
	import marble_ctl_pkg::*;

	localparam int div_w      = $clog2(clk_div);
	localparam int half_total = 2 * dac_w;

	logic [div_w-1:0] div_cnt;
	logic [5:0]       half_cnt;

	assign half_tick = run && (div_cnt == div_w'(clk_div - 1));
	// Tick that ends the final falling half period
	assign last_bit  = (half_cnt == 6'(half_total - 1));

	always_ff @(posedge lb_clk) begin
		if (reset || !run) begin
			div_cnt  <= '0;
			half_cnt <= '0;
			sclk     <= 1'b0;
		end else begin
			div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
			// Ticks past the 48th pace sync_hold only
			if (half_tick && half_cnt != 6'(half_total)) begin
				half_cnt <= half_cnt + 6'd1;
				sclk     <= ~sclk;
			end
		end
	end

endmodule

// File: dac_shifter.sv
// ==========================================================================
// MSB-first DAC shifter; DIN moves on SCLK rise, the DAC samples on fall
// ==========================================================================
`timescale 1ns/1ns

module dac_shifter (
	input  logic lb_clk,
	input  logic reset,
	input  logic load,
	input  logic half_tick,
	input  logic sclk,
	input  logic sync_en,
	dac_if.engine dac,
	output logic din,
	output logic sync1,
	output logic sync2
);
	import marble_ctl_pkg::*;

	// MSB doubled since the first rising tick shifts too
	logic [dac_w:0] shreg;
	logic           chan_q;
	logic           chan_sel;

	always_ff @(posedge lb_clk) begin
		if (reset)
			shreg <= '0;
		else if (load)
			shreg <= {dac.data[dac_w-1], dac.data};
		// Tick with sclk low means a rising edge comes next
		else if (half_tick && !sclk)
			shreg <= {shreg[dac_w-1:0], 1'b0};
	end

	always_ff @(posedge lb_clk) begin
		if (load)
			chan_q <= dac.channel;
	end

	// Load cycle already has sync low, channel not latched yet
	assign chan_sel = load ? dac.channel : chan_q;

	assign din   = shreg[dac_w];
	assign sync1 = ~(sync_en & ~chan_sel);
	assign sync2 = ~(sync_en & chan_sel);

endmodule

// File: marble_ctl_top.sv
// ==========================================================================
// Board-control core with board pin names; LEDs and DAC sit behind SPI
// ==========================================================================
`timescale 1ns/1ns

module marble_ctl_top #(
	parameter int clk_div = 4
) (
	input  logic       lb_clk,
	input  logic       reset,
	input  logic       SCLK,
	input  logic       CSB,
	input  logic       MOSI,
	input  logic [7:0] Pmod2,
	output logic       MISO,
	output logic       LD16,
	output logic       LD17,
	output logic [7:0] Pmod1,
	output logic       WR_DAC_SCLK,
	output logic       WR_DAC_DIN,
	output logic       WR_DAC1_SYNC,
	output logic       WR_DAC2_SYNC
);

	lb_if  lb ();
	dac_if dac ();

	// Sequencer to timer and shifter
	logic timer_run;
	logic shift_load;
	logic sync_en;
	logic half_tick;
	logic last_bit;

	spi_lb_bridge i_spi_lb_bridge (
		.lb_clk (lb_clk),
		.reset  (reset),
		.sclk   (SCLK),
		.csb    (CSB),
		.mosi   (MOSI),
		.miso   (MISO),
		.lb     (lb.master)
	);

	// LED register bits 9..2 Pmod1, bit 1 LD17, bit 0 LD16
	ctl_reg_bank i_ctl_reg_bank (
		.lb_clk  (lb_clk),
		.reset   (reset),
		.pmod_in (Pmod2),
		.led_out ({Pmod1, LD17, LD16}),
		.lb      (lb.slave),
		.dac     (dac.host)
	);

	dac_seq_fsm i_dac_seq_fsm (
		.lb_clk     (lb_clk),
		.reset      (reset),
		.half_tick  (half_tick),
		.last_bit   (last_bit),
		.timer_run  (timer_run),
		.shift_load (shift_load),
		.sync_en    (sync_en),
		.dac        (dac.engine)
	);

	dac_bit_timer #(
		.clk_div (clk_div)
	) i_dac_bit_timer (
		.lb_clk    (lb_clk),
		.reset     (reset),
		.run       (timer_run),
		.half_tick (half_tick),
		.sclk      (WR_DAC_SCLK),
		.last_bit  (last_bit)
	);

	dac_shifter i_dac_shifter (
		.lb_clk    (lb_clk),
		.reset     (reset),
		.load      (shift_load),
		.half_tick (half_tick),
		.sclk      (WR_DAC_SCLK),
		.sync_en   (sync_en),
		.dac       (dac.engine),
		.din       (WR_DAC_DIN),
		.sync1     (WR_DAC1_SYNC),
		.sync2     (WR_DAC2_SYNC)
	);

endmodule

// File: marble_ctl_checker.sv
// ==========================================================================
// Register model and comparator; samples DUT pins on the falling lb_clk edge
// Status reads assume no DAC transfer is in flight when they are issued
// ==========================================================================
`timescale 1ns/1ns

module marble_ctl_checker (
	input  logic       lb_clk,
	input  logic       reset,
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,
	input  logic       miso,
	input  logic [7:0] pmod2,
	input  logic       ld16,
	input  logic       ld17,
	input  logic [7:0] pmod1,
	input  logic       dac_sclk,
	input  logic       dac_din,
	input  logic       dac1_sync,
	input  logic       dac2_sync,
	output int         err_cnt,
	output int         chk_cnt
);
	import marble_ctl_pkg::*;

	logic        sclk_p, csb_p, dsclk_p, sync1_p, sync2_p;
	logic        idle_seen;
	int          bit_n;
	logic [39:0] frame;
	logic [31:0] rx_word;
	logic [31:0] exp_rd;
	// Register model
	logic [9:0]  led_m;
	logic [23:0] dac1_m;
	logic [23:0] dac2_m;
	logic        busy_m;
	logic [7:0]  done_m;
	// Transfer expected on the DAC pins
	logic [23:0] dac_exp;
	logic        chan_exp;
	logic [23:0] dac_rx;
	int          dac_bits;
	int          led_wait;
	// Cycles left for an accepted command to pull a sync low
	int          open_wait;

	function automatic logic [31:0] model_read(input logic [6:0] a);
		case (a)
			7'd0:    return 32'h4d52424c;
			7'd1:    return {22'h0, led_m};
			7'd2:    return {8'h0, dac1_m};
			7'd3:    return {8'h0, dac2_m};
			7'd5:    return {8'h0, pmod2, done_m, 7'h0, busy_m};
			default: return 32'hfaceface;
		endcase
	endfunction

	always @(negedge lb_clk) begin
		if (reset) begin
			led_m     = '0;
			dac1_m    = '0;
			dac2_m    = '0;
			busy_m    = 1'b0;
			done_m    = '0;
			bit_n     = 0;
			led_wait  = 0;
			open_wait = 0;
			dac_bits  = 0;
			idle_seen = 1'b0;
			err_cnt   = 0;
			chk_cnt   = 0;
		end else begin
			// Idle levels straight after reset
			if (!idle_seen) begin
				idle_seen = 1'b1;
				chk_cnt++;
				if (!dac1_sync || !dac2_sync || dac_sclk || dac_din || miso ||
						ld16 || ld17 || pmod1 != 8'h00) begin
					$display("Output pins not at their reset levels after reset");
					err_cnt++;
				end
			end
			// LED pins settle a few cycles after CSB rises
			if (led_wait > 0) begin
				led_wait--;
				if (led_wait == 0) begin
					chk_cnt++;
					if ({pmod1, ld17, ld16} != led_m) begin
						$display("ERR led_out got %h exp %h", {pmod1, ld17, ld16}, led_m);
						err_cnt++;
					end
				end
			end
			// Sync goes low a handful of cycles after the command frame ends
			if (open_wait > 0) begin
				open_wait--;
				if (open_wait == 0) begin
					$display("DAC command accepted but no sync window opened");
					err_cnt++;
				end
			end
			// SPI frame decode
			if (!csb && csb_p)
				bit_n = 0;
			if (!csb && sclk && !sclk_p && bit_n < 40) begin
				frame = {frame[38:0], mosi};
				if (bit_n >= 8)
					rx_word = {rx_word[30:0], miso};
				bit_n++;
				// Read value fixed when the command byte is complete
				if (bit_n == 8 && frame[7])
					exp_rd = model_read(frame[6:0]);
			end
			if (csb && !csb_p && bit_n == 40) begin
				if (frame[39]) begin
					chk_cnt++;
					if (rx_word != exp_rd) begin
						$display("ERR miso addr %h got %h exp %h", frame[38:32], rx_word, exp_rd);
						err_cnt++;
					end
				end else begin
					case (frame[38:32])
						7'd1: begin
							led_m    = frame[9:0];
							led_wait = 6;
						end
						7'd2: dac1_m = frame[23:0];
						7'd3: dac2_m = frame[23:0];
						7'd4: begin
							// Dropped while a transfer runs
							if (!busy_m) begin
								busy_m    = 1'b1;
								chan_exp  = frame[0];
								dac_exp   = frame[0] ? dac2_m : dac1_m;
								open_wait = 12;
							end
						end
						default: ;
					endcase
				end
			end
			// DAC serial decode
			if ((!dac1_sync && sync1_p) || (!dac2_sync && sync2_p)) begin
				dac_bits  = 0;
				open_wait = 0;
				chk_cnt++;
				if (!busy_m || (!dac1_sync && chan_exp) || (!dac2_sync && !chan_exp)) begin
					$display("DAC sync window opened without a matching command");
					err_cnt++;
				end
			end
			if (dsclk_p && !dac_sclk && (!dac1_sync || !dac2_sync)) begin
				dac_rx = {dac_rx[22:0], dac_din};
				dac_bits++;
			end
			if ((dac1_sync && !sync1_p) || (dac2_sync && !sync2_p)) begin
				chk_cnt++;
				if (dac_bits != 24) begin
					$display("DAC window held %0d bits instead of 24", dac_bits);
					err_cnt++;
				end else if (dac_rx != dac_exp) begin
					$display("ERR dac_din got %h exp %h", dac_rx, dac_exp);
					err_cnt++;
				end
				busy_m = 1'b0;
				done_m = done_m + 8'd1;
			end
		end
		sclk_p  = sclk;
		csb_p   = csb;
		dsclk_p = dac_sclk;
		sync1_p = dac1_sync;
		sync2_p = dac2_sync;
	end

endmodule

// File: marble_ctl_sva.sv
// ==========================================================================
// Bound assertions for DAC handshake, sync lines and local-bus read timing
// ==========================================================================
`timescale 1ns/1ns

module marble_ctl_sva (
	input logic lb_clk,
	input logic reset,
	input logic sync1,
	input logic sync2,
	input logic req,
	input logic ack,
	input logic strobe,
	input logic rd,
	input logic rd_valid
);

	// Only one DAC selected at a time
	sync_exclusive: assert property (@(posedge lb_clk) disable iff (reset)
		sync1 || sync2) else $error("both DAC syncs low");

	ack_needs_req: assert property (@(posedge lb_clk) disable iff (reset)
		$rose(ack) |-> req) else $error("ack rose without req");

	req_after_ack: assert property (@(posedge lb_clk) disable iff (reset)
		$fell(req) |-> $past(ack)) else $error("req fell before ack");

	rd_valid_follows: assert property (@(posedge lb_clk) disable iff (reset)
		(strobe && rd) |=> rd_valid) else $error("rd_valid missing after read strobe");

	rd_valid_cause: assert property (@(posedge lb_clk) disable iff (reset)
		rd_valid |-> $past(strobe && rd)) else $error("rd_valid without read strobe");

endmodule

bind marble_ctl_top marble_ctl_sva i_marble_ctl_sva (
	.lb_clk   (lb_clk),
	.reset    (reset),
	.sync1    (WR_DAC1_SYNC),
	.sync2    (WR_DAC2_SYNC),
	.req      (dac.req),
	.ack      (dac.ack),
	.strobe   (lb.strobe),
	.rd       (lb.rd),
	.rd_valid (lb.rd_valid)
);

// File: tb_marble_ctl.sv
// ==========================================================================
// Random SPI traffic against the board-control core, clk_div 16, fixed seed
// ==========================================================================
`timescale 1ns/1ns

module tb_marble_ctl;
	import marble_ctl_pkg::*;

	localparam int half_sclk      = 8;
	localparam int n_frames       = 200;
	// About 670 cycles a frame plus idle waits of up to 800
	localparam int timeout_cycles = 250000;

	logic        lb_clk, reset, sclk, csb, mosi, miso, ld16, ld17;
	logic        dac_sclk, dac_din, dac1_sync, dac2_sync;
	logic [7:0]  pmod2, pmod1;
	int          err_cnt, chk_cnt, cycles, kind;
	int unsigned seed_ret;
	logic [6:0]  addr;

	marble_ctl_top #(.clk_div(16)) i_marble_ctl_top (
		.lb_clk (lb_clk), .reset (reset), .SCLK (sclk), .CSB (csb), .MOSI (mosi),
		.Pmod2 (pmod2), .MISO (miso), .LD16 (ld16), .LD17 (ld17), .Pmod1 (pmod1),
		.WR_DAC_SCLK (dac_sclk), .WR_DAC_DIN (dac_din),
		.WR_DAC1_SYNC (dac1_sync), .WR_DAC2_SYNC (dac2_sync)
	);

	marble_ctl_checker i_checker (
		.lb_clk (lb_clk), .reset (reset), .sclk (sclk), .csb (csb), .mosi (mosi),
		.miso (miso), .pmod2 (pmod2), .ld16 (ld16), .ld17 (ld17), .pmod1 (pmod1),
		.dac_sclk (dac_sclk), .dac_din (dac_din), .dac1_sync (dac1_sync),
		.dac2_sync (dac2_sync), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
	);

	initial begin
		lb_clk = 1'b0;
		forever #10 lb_clk = ~lb_clk;
	end

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge lb_clk);
			cycles++;
		end
		$display("Run stopped by timeout after %0d cycles", cycles);
		$display("TEST FAILED");
		$finish;
	end

	// Inputs change 2 ns after the rising edge
	task automatic step(input int n);
		repeat (n) @(posedge lb_clk);
		#2;
	endtask

	task automatic spi_frame(input logic is_rd, input logic [6:0] a, input logic [31:0] d);
		logic [39:0] f;
		f   = {is_rd, a, d};
		csb = 1'b0;
		step(half_sclk);
		for (int i = 39; i >= 0; i--) begin
			mosi = f[i];
			step(half_sclk);
			sclk = 1'b1;
			step(half_sclk);
			sclk = 1'b0;
		end
		step(half_sclk);
		csb  = 1'b1;
		mosi = 1'b0;
		step(10);
	endtask

	// Both syncs high means no transfer running
	task automatic wait_dac_idle();
		while (!dac1_sync || !dac2_sync)
			step(1);
		step(10);
	endtask

	initial begin
		seed_ret = $urandom(32'h2487_c07e);
		reset = 1'b1;
		sclk  = 1'b0;
		csb   = 1'b1;
		mosi  = 1'b0;
		pmod2 = 8'h00;
		repeat (8) @(posedge lb_clk);
		#2;
		reset = 1'b0;
		step(4);
		// ID and one hole in the map first
		spi_frame(1'b1, 7'(reg_id), 32'h0);
		spi_frame(1'b1, 7'd7, 32'h0);
		for (int n = 2; n < n_frames; n++) begin
			kind = int'($urandom_range(0, 9));
			addr = 7'($urandom_range(0, 7));
			if ($urandom_range(0, 3) == 0)
				pmod2 = 8'($urandom);
			if (kind < 4) begin
				if (addr == 7'(reg_status))
					wait_dac_idle();
				spi_frame(1'b1, addr, 32'h0);
			end else if (kind < 7) begin
				spi_frame(1'b0, addr, $urandom);
			end else begin
				// Commands sent without waiting may land while busy
				if ($urandom_range(0, 1) == 1)
					wait_dac_idle();
				spi_frame(1'b0, 7'(reg_dac_cmd), 32'($urandom_range(0, 1)));
			end
		end
		wait_dac_idle();
		$display("Errors %0d, checks %0d", err_cnt, chk_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: marble_ctl.f
marble_ctl_pkg.sv
lb_if.sv
dac_if.sv
spi_lb_bridge.sv
ctl_reg_bank.sv
dac_seq_fsm.sv
dac_bit_timer.sv
dac_shifter.sv
marble_ctl_top.sv
marble_ctl_checker.sv
marble_ctl_sva.sv
tb_marble_ctl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f marble_ctl.f \
	--top-module tb_marble_ctl -o sim_marble_ctl

out=$(./obj_dir/sim_marble_ctl)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
	exit 0
else
	exit 1
fi
